/* rtl/ecc_decode32.sv */
// SECDED decoder and policy
`include "ecc_defines.svh"

module ecc_decode32 (
    input  ecc_pkg::ecc_ctrl_t ctrl,
    input  logic [31:0]        data,
    input  logic [6:0]         parin,
    output logic [31:0]        dataout,
    output logic [6:0]         parout,
    output logic               error,
    output logic               sec,
    output logic               ded,
    output logic               xcpt,
    output logic               replay,
    output logic               invalidate
);

    localparam logic [31:0] H_ROW [7] = '{
        `ECC_H_ROW0,
        `ECC_H_ROW1,
        `ECC_H_ROW2,
        `ECC_H_ROW3,
        `ECC_H_ROW4,
        `ECC_H_ROW5,
        `ECC_H_ROW6
    };

    logic [6:0]  calc_par;
    logic [6:0]  syndrome;
    logic [31:0] data_flip;
    logic        syn_nz;
    logic        data_hit;
    logic        chk_hit;
    logic        in_table;

    // Syndrome of data bit idx.
    function automatic logic [6:0] h_column(input int idx);
        logic [6:0] col;
        for (int r = 0; r < 7; r++) begin
            col[r] = H_ROW[r][idx];
        end
        return col;
    endfunction

    ecc_encode32 u_enc (
        .data   (data),
        .parity (calc_par)
    );

    assign syndrome = parin ^ calc_par;
    assign syn_nz   = |syndrome;

    // ****************************************
    // Syndrome lookup.
    // ****************************************
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            data_flip[i] = (syndrome == h_column(i));
        end
    end

    assign data_hit = |data_flip;
    // One-hot syndrome points at a check bit.
    assign chk_hit  = syn_nz && ((syndrome & (syndrome - 7'd1)) == 7'd0);
    assign in_table = data_hit | chk_hit;

    assign dataout = data ^ (data_flip & {32{ctrl.check_en}});
    assign parout  = parin ^ ((chk_hit && ctrl.check_en) ? syndrome : 7'd0);

    // ****************************************
    // Status and policy.
    // ****************************************
    assign error      = ctrl.check_en & syn_nz;
    assign sec        = ctrl.check_en & in_table;
    assign ded        = ctrl.check_en & syn_nz & ~in_table;
    assign xcpt       = (sec & ctrl.report_1bit) | (ded & ctrl.report_2bit);
    assign replay     = sec & ctrl.correct_1bit & ~xcpt;
    assign invalidate = ded & ~ctrl.report_2bit;

endmodule

/* rtl/ecc_defines.svh */
// ECC memory parameters
`ifndef ECC_DEFINES_SVH
`define ECC_DEFINES_SVH

// ****************************************
// Geometry.
// ****************************************
`define ECC_MEM_AW        8
`define ECC_ADR_W         13
`define ECC_REG_SEL_BIT   12

// Register window byte offsets.
`define ECC_REG_CTRL      12'h000
`define ECC_REG_INJECT    12'h004
`define ECC_REG_SEC_CNT   12'h008
`define ECC_REG_DED_CNT   12'h00C
`define ECC_REG_LAST_ADDR 12'h010

// ****************************************
// Hamming check matrix, one data mask per check bit.
// ****************************************
`define ECC_H_ROW0 32'h56AA_AD5B
`define ECC_H_ROW1 32'h9B33_366D
`define ECC_H_ROW2 32'hE3C3_C78E
`define ECC_H_ROW3 32'h03FC_07F0
`define ECC_H_ROW4 32'h03FF_F800
`define ECC_H_ROW5 32'hFC00_0000
`define ECC_H_ROW6 32'h2DA6_5CB7

`endif

/* rtl/ecc_encode32.sv */
// SECDED check bit generator
`include "ecc_defines.svh"

module ecc_encode32 (
    input  logic [31:0] data,
    output logic [6:0]  parity
);

    localparam logic [31:0] H_ROW [7] = '{
        `ECC_H_ROW0,
        `ECC_H_ROW1,
        `ECC_H_ROW2,
        `ECC_H_ROW3,
        `ECC_H_ROW4,
        `ECC_H_ROW5,
        `ECC_H_ROW6
    };

    // Each check bit covers the data bits of its matrix row.
    always_comb begin
        for (int i = 0; i < 7; i++) begin
            parity[i] = ^(data & H_ROW[i]);
        end
    end

endmodule

/* rtl/ecc_error_log.sv */
// ECC control and error log registers
`include "ecc_defines.svh"

module ecc_error_log (
    input  logic                          clk,
    input  logic                          reset,
    input  ecc_pkg::ecc_event_t           rd_event,
    input  logic                          reg_we,
    input  logic [`ECC_REG_SEL_BIT-1:0]   reg_off,
    input  logic [31:0]                   reg_wdata,
    input  logic                          inject_used,
    output logic [31:0]                   reg_rdata,
    output ecc_pkg::ecc_ctrl_t            ctrl,
    output ecc_pkg::ecc_inject_t          inject
);

    logic [31:0]            sec_cnt;
    logic [31:0]            ded_cnt;
    logic [`ECC_MEM_AW-1:0] last_addr;
    logic                   wr_ctrl;
    logic                   wr_inject;
    logic                   wr_sec;
    logic                   wr_ded;

    assign wr_ctrl   = reg_we && (reg_off == `ECC_REG_CTRL);
    assign wr_inject = reg_we && (reg_off == `ECC_REG_INJECT);
    assign wr_sec    = reg_we && (reg_off == `ECC_REG_SEC_CNT);
    assign wr_ded    = reg_we && (reg_off == `ECC_REG_DED_CNT);

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl      <= '0;
            inject    <= '0;
            sec_cnt   <= '0;
            ded_cnt   <= '0;
            last_addr <= '0;
        end else begin
            if (wr_ctrl) begin
                ctrl <= reg_wdata[$bits(ecc_pkg::ecc_ctrl_t)-1:0];
            end
            // Injection is one-shot.
            if (inject_used) begin
                inject <= '0;
            end else if (wr_inject) begin
                inject <= reg_wdata[$bits(ecc_pkg::ecc_inject_t)-1:0];
            end
            // Counters saturate, any write clears.
            if (wr_sec) begin
                sec_cnt <= '0;
            end else if (rd_event.valid && rd_event.single && (sec_cnt != '1)) begin
                sec_cnt <= sec_cnt + 32'd1;
            end
            if (wr_ded) begin
                ded_cnt <= '0;
            end else if (rd_event.valid && rd_event.multi && (ded_cnt != '1)) begin
                ded_cnt <= ded_cnt + 32'd1;
            end
            if (rd_event.valid && (rd_event.single || rd_event.multi)) begin
                last_addr <= rd_event.addr;
            end
        end
    end

    always_comb begin
        case (reg_off)
            `ECC_REG_CTRL:      reg_rdata = {28'd0, ctrl};
            `ECC_REG_INJECT:    reg_rdata = {18'd0, inject};
            `ECC_REG_SEC_CNT:   reg_rdata = sec_cnt;
            `ECC_REG_DED_CNT:   reg_rdata = ded_cnt;
            `ECC_REG_LAST_ADDR: reg_rdata = {{(32-`ECC_MEM_AW){1'b0}}, last_addr};
            default:            reg_rdata = 32'd0;
        endcase
    end

endmodule

/* rtl/ecc_mem_top.sv */
// ECC protected memory top
`include "ecc_defines.svh"

module ecc_mem_top (
    input  logic             clk,
    input  logic             reset,
    input  ecc_pkg::wb_req_t wb_req,
    output ecc_pkg::wb_rsp_t wb_rsp
);

    logic [`ECC_MEM_AW-1:0]      mem_addr;
    logic                        mem_we;
    logic [31:0]                 mem_wdata;
    logic                        raw_we;
    ecc_pkg::ecc_word_t          raw_word;
    ecc_pkg::ecc_word_t          rword;
    logic [31:0]                 dec_data;
    logic [6:0]                  dec_par;
    logic                        dec_error;
    logic                        dec_sec;
    logic                        dec_ded;
    logic                        dec_xcpt;
    logic                        dec_replay;
    logic                        dec_invalidate;
    ecc_pkg::ecc_event_t         rd_event;
    logic                        reg_we;
    logic [`ECC_REG_SEL_BIT-1:0] reg_off;
    logic [31:0]                 reg_wdata;
    logic                        inject_used;
    logic [31:0]                 reg_rdata;
    ecc_pkg::ecc_ctrl_t          ctrl;
    ecc_pkg::ecc_inject_t        inject;

    ecc_wb_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .wb_req         (wb_req),
        .wb_rsp         (wb_rsp),
        .mem_addr       (mem_addr),
        .mem_we         (mem_we),
        .mem_wdata      (mem_wdata),
        .raw_we         (raw_we),
        .raw_word       (raw_word),
        .dec_data       (dec_data),
        .dec_par        (dec_par),
        .dec_error      (dec_error),
        .dec_sec        (dec_sec),
        .dec_ded        (dec_ded),
        .dec_xcpt       (dec_xcpt),
        .dec_replay     (dec_replay),
        .dec_invalidate (dec_invalidate),
        .rd_event       (rd_event),
        .reg_we         (reg_we),
        .reg_off        (reg_off),
        .reg_wdata      (reg_wdata),
        .inject_used    (inject_used),
        .reg_rdata      (reg_rdata)
    );

    // ****************************************
    // Storage path.
    // ****************************************
    ecc_store u_store (
        .clk      (clk),
        .reset    (reset),
        .addr     (mem_addr),
        .we       (mem_we),
        .wdata    (mem_wdata),
        .raw_we   (raw_we),
        .raw_word (raw_word),
        .inject   (inject),
        .rword    (rword)
    );

    ecc_decode32 u_dec (
        .ctrl       (ctrl),
        .data       (rword.data),
        .parin      (rword.chk),
        .dataout    (dec_data),
        .parout     (dec_par),
        .error      (dec_error),
        .sec        (dec_sec),
        .ded        (dec_ded),
        .xcpt       (dec_xcpt),
        .replay     (dec_replay),
        .invalidate (dec_invalidate)
    );

    // ****************************************
    // Status path.
    // ****************************************
    ecc_error_log u_log (
        .clk         (clk),
        .reset       (reset),
        .rd_event    (rd_event),
        .reg_we      (reg_we),
        .reg_off     (reg_off),
        .reg_wdata   (reg_wdata),
        .inject_used (inject_used),
        .reg_rdata   (reg_rdata),
        .ctrl        (ctrl),
        .inject      (inject)
    );

endmodule

/* rtl/ecc_pkg.sv */
// ECC memory types
`include "ecc_defines.svh"

package ecc_pkg;

    // Codeword as stored, positions 32..38 are the check bits.
    typedef struct packed {
        logic [6:0]  chk;
        logic [31:0] data;
    } ecc_word_t;

    // ****************************************
    // Wishbone classic.
    // ****************************************
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`ECC_ADR_W-1:0] adr;
        logic [31:0]           dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] dat;
    } wb_rsp_t;

    // ****************************************
    // Policy, injection and status.
    // ****************************************
    typedef struct packed {
        logic check_en;
        logic correct_1bit;
        logic report_1bit;
        logic report_2bit;
    } ecc_ctrl_t;

    typedef struct packed {
        logic       a_en;
        logic [5:0] a_pos;
        logic       b_en;
        logic [5:0] b_pos;
    } ecc_inject_t;

    typedef struct packed {
        logic                   valid;
        logic                   single;
        logic                   multi;
        logic [`ECC_MEM_AW-1:0] addr;
    } ecc_event_t;

endpackage

/* rtl/ecc_store.sv */
// ECC word array
`include "ecc_defines.svh"

module ecc_store (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`ECC_MEM_AW-1:0]   addr,
    input  logic                     we,
    input  logic [31:0]              wdata,
    input  logic                     raw_we,
    input  ecc_pkg::ecc_word_t       raw_word,
    input  ecc_pkg::ecc_inject_t     inject,
    output ecc_pkg::ecc_word_t       rword
);

    localparam int DEPTH  = 1 << `ECC_MEM_AW;
    localparam int WORD_W = $bits(ecc_pkg::ecc_word_t);

    ecc_pkg::ecc_word_t mem [DEPTH];
    ecc_pkg::ecc_word_t wr_word;
    logic [6:0]         enc_par;
    logic [WORD_W-1:0]  flip;

    ecc_encode32 u_enc (
        .data   (wdata),
        .parity (enc_par)
    );

    // Injected flips, the same position twice cancels out.
    always_comb begin
        flip = '0;
        if (inject.a_en && (inject.a_pos < 6'(WORD_W))) begin
            flip[inject.a_pos] = 1'b1;
        end
        if (inject.b_en && (inject.b_pos < 6'(WORD_W))) begin
            flip[inject.b_pos] = ~flip[inject.b_pos];
        end
    end

    assign wr_word = {enc_par, wdata} ^ flip;

    // Writes are held off during reset.
    always_ff @(posedge clk) begin
        if (!reset) begin
            if (raw_we) begin
                mem[addr] <= raw_word;
            end else if (we) begin
                mem[addr] <= wr_word;
            end
        end
        rword <= mem[addr];
    end

endmodule

/* rtl/ecc_wb_ctrl.sv */
// Wishbone slave controller
`include "ecc_defines.svh"

module ecc_wb_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    input  ecc_pkg::wb_req_t              wb_req,
    output ecc_pkg::wb_rsp_t              wb_rsp,
    // Store.
    output logic [`ECC_MEM_AW-1:0]        mem_addr,
    output logic                          mem_we,
    output logic [31:0]                   mem_wdata,
    output logic                          raw_we,
    output ecc_pkg::ecc_word_t            raw_word,
    // Decoder.
    input  logic [31:0]                   dec_data,
    input  logic [6:0]                    dec_par,
    input  logic                          dec_error,
    input  logic                          dec_sec,
    input  logic                          dec_ded,
    input  logic                          dec_xcpt,
    input  logic                          dec_replay,
    input  logic                          dec_invalidate,
    // Error log.
    output ecc_pkg::ecc_event_t           rd_event,
    output logic                          reg_we,
    output logic [`ECC_REG_SEL_BIT-1:0]   reg_off,
    output logic [31:0]                   reg_wdata,
    output logic                          inject_used,
    input  logic [31:0]                   reg_rdata
);

    // Store data and decode are valid in DECIDE.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DECIDE,
        ST_WRITEBACK,
        ST_RESPOND
    } state_t;

    state_t                 state;
    logic                   ack_q;
    logic                   err_q;
    logic [31:0]            dat_q;
    logic [`ECC_MEM_AW-1:0] adr_q;
    ecc_pkg::ecc_word_t     wb_word_q;
    logic                   start;
    logic                   reg_sel;

    assign start   = (state == ST_IDLE) && wb_req.cyc && wb_req.stb;
    assign reg_sel = wb_req.adr[`ECC_REG_SEL_BIT];

    // ****************************************
    // Store and log strobes.
    // ****************************************
    assign mem_addr    = (state == ST_IDLE) ? wb_req.adr[`ECC_MEM_AW+1:2] : adr_q;
    assign mem_we      = start && wb_req.we && !reg_sel;
    assign mem_wdata   = wb_req.dat;
    assign inject_used = mem_we;
    assign raw_we      = (state == ST_WRITEBACK);
    assign raw_word    = wb_word_q;
    assign reg_we      = start && wb_req.we && reg_sel;
    assign reg_off     = wb_req.adr[`ECC_REG_SEL_BIT-1:0];
    assign reg_wdata   = wb_req.dat;

    always_comb begin
        rd_event.valid  = (state == ST_DECIDE);
        rd_event.single = dec_sec;
        rd_event.multi  = dec_ded;
        rd_event.addr   = adr_q;
    end

    assign wb_rsp = '{ack: ack_q, err: err_q, dat: dat_q};

    // ****************************************
    // FSM.
    // ****************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        if (wb_req.we || reg_sel) begin
                            ack_q <= 1'b1;
                            state <= ST_RESPOND;
                        end else begin
                            state <= ST_DECIDE;
                        end
                    end
                end
                ST_DECIDE: begin
                    if (dec_error && dec_xcpt) begin
                        err_q <= 1'b1;
                        state <= ST_RESPOND;
                    end else if (dec_error && (dec_replay || dec_invalidate)) begin
                        state <= ST_WRITEBACK;
                    end else begin
                        ack_q <= 1'b1;
                        state <= ST_RESPOND;
                    end
                end
                ST_WRITEBACK: begin
                    ack_q <= 1'b1;
                    state <= ST_RESPOND;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Response payload and write-back word.
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= wb_req.adr[`ECC_MEM_AW+1:2];
            dat_q <= reg_sel ? reg_rdata : 32'd0;
        end
        if (state == ST_DECIDE) begin
            dat_q     <= dec_invalidate ? 32'd0 : dec_data;
            wb_word_q <= dec_invalidate ? '0 : {dec_par, dec_data};
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ECC memory simulation with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f sim.f --top-module ecc_mem_tb -Mdir obj_dir -o ecc_mem_sim

./obj_dir/ecc_mem_sim > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"

/* sim.f */
+incdir+rtl
+incdir+tb
rtl/ecc_pkg.sv
rtl/ecc_encode32.sv
rtl/ecc_decode32.sv
rtl/ecc_store.sv
rtl/ecc_error_log.sv
rtl/ecc_wb_ctrl.sv
rtl/ecc_mem_top.sv
tb/ecc_mem_tb.sv

/* tb/ecc_model.svh */
// ECC reference model
`ifndef ECC_MODEL_SVH
`define ECC_MODEL_SVH

// Codewords as the array should hold them.
ecc_pkg::ecc_word_t shadow [1 << `ECC_MEM_AW];

// Data bit idx sits at the idx-th non power of two Hamming position.
// The top syndrome bit makes every column odd weight.
function automatic logic [6:0] data_column(input int idx);
    int         pos;
    int         count;
    logic [5:0] p6;
    pos   = 0;
    count = -1;
    while (count < idx) begin
        pos++;
        if ((pos & (pos - 1)) != 0) begin
            count++;
        end
    end
    p6 = 6'(pos);
    return {~^p6, p6};
endfunction

function automatic logic [6:0] calc_parity(input logic [31:0] data);
    logic [6:0] par;
    par = '0;
    for (int i = 0; i < 32; i++) begin
        if (data[i]) begin
            par ^= data_column(i);
        end
    end
    return par;
endfunction

// Data bit named by a syndrome, or -1.
function automatic int syndrome_bit(input logic [6:0] syn);
    int idx;
    idx = -1;
    for (int i = 0; i < 32; i++) begin
        if (syn == data_column(i)) begin
            idx = i;
        end
    end
    return idx;
endfunction

// Positions 0..31 are data bits, 32..38 check bits.
function automatic ecc_pkg::ecc_word_t apply_inject(input ecc_pkg::ecc_word_t word,
                                                    input ecc_pkg::ecc_inject_t inj);
    logic [38:0] bits;
    bits = word;
    if (inj.a_en) begin
        bits[inj.a_pos] = ~bits[inj.a_pos];
    end
    if (inj.b_en) begin
        bits[inj.b_pos] = ~bits[inj.b_pos];
    end
    return bits;
endfunction

// Response, counter events and stored word after one read.
function automatic void predict_read(input  ecc_pkg::ecc_ctrl_t ctrl,
                                     input  ecc_pkg::ecc_word_t word,
                                     output logic               is_err,
                                     output logic [31:0]        rdata,
                                     output logic               single,
                                     output logic               multi,
                                     output ecc_pkg::ecc_word_t new_word);
    logic [6:0] syn;
    int         idx;
    syn      = word.chk ^ calc_parity(word.data);
    idx      = syndrome_bit(syn);
    is_err   = 1'b0;
    rdata    = word.data;
    single   = 1'b0;
    multi    = 1'b0;
    new_word = word;
    if (ctrl.check_en && (syn != 7'd0)) begin
        if ((idx >= 0) || ($countones(syn) == 1)) begin
            single = 1'b1;
            if (idx >= 0) begin
                rdata[idx] = ~rdata[idx];
            end
            if (ctrl.report_1bit) begin
                is_err = 1'b1;
            end else if (ctrl.correct_1bit) begin
                new_word = '{chk: calc_parity(rdata), data: rdata};
            end
        end else begin
            multi = 1'b1;
            if (ctrl.report_2bit) begin
                is_err = 1'b1;
            end else begin
                rdata    = 32'd0;
                new_word = '0;
            end
        end
    end
endfunction

`endif

/* tb/ecc_mem_tb.sv */
// ECC memory testbench
`include "ecc_defines.svh"

module ecc_mem_tb;

    localparam int N_CLEAN    = 16;
    localparam int N_SEC      = 4;
    localparam int N_REP      = 2;
    localparam int N_DED      = 2;
    localparam int N_ALIAS    = 5;
    // Upper bound on the bus transactions issued below.
    localparam int TXN_TOTAL  = 3 * N_CLEAN + 7 * N_SEC + 4 * N_REP + 9 * N_DED
                                + 2 * N_ALIAS + 40;
    localparam int MAX_CYCLES = 8 * TXN_TOTAL + 16 + 200;

    logic             clk;
    logic             reset;
    ecc_pkg::wb_req_t wb_req;
    ecc_pkg::wb_rsp_t wb_rsp;

    // Register state of the model.
    ecc_pkg::ecc_ctrl_t     ctrl_m;
    ecc_pkg::ecc_inject_t   inject_m;
    logic [31:0]            sec_m;
    logic [31:0]            ded_m;
    logic [`ECC_MEM_AW-1:0] last_m;
    logic [`ECC_MEM_AW-1:0] clean_addr [N_CLEAN];

    // Pending responses as {check data, err, data}.
    logic [33:0]           pending_q [$];
    logic [`ECC_ADR_W-1:0] pending_adr_q [$];
    int                    error_count = 0;
    int                    check_count = 0;
    int                    cycle_count = 0;

    `include "ecc_model.svh"

    ecc_mem_top DUT (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ****************************************
    // Bus access.
    // ****************************************
    function automatic logic [`ECC_ADR_W-1:0] mem_adr(input logic [`ECC_MEM_AW-1:0] a);
        return {{(`ECC_ADR_W-`ECC_MEM_AW-2){1'b0}}, a, 2'b00};
    endfunction

    function automatic logic [31:0] reg_model(input logic [`ECC_REG_SEL_BIT-1:0] off);
        case (off)
            `ECC_REG_CTRL:      return {28'd0, ctrl_m};
            `ECC_REG_INJECT:    return {18'd0, inject_m};
            `ECC_REG_SEC_CNT:   return sec_m;
            `ECC_REG_DED_CNT:   return ded_m;
            `ECC_REG_LAST_ADDR: return {{(32-`ECC_MEM_AW){1'b0}}, last_m};
            default:            return 32'd0;
        endcase
    endfunction

    function automatic logic [5:0] other_pos(input logic [5:0] pa);
        logic [5:0] pb;
        pb = pa;
        while (pb == pa) begin
            pb = 6'($urandom_range(38, 0));
        end
        return pb;
    endfunction

    task automatic bus_cycle(input logic we, input logic [`ECC_ADR_W-1:0] adr,
                             input logic [31:0] dat, input logic chk_dat,
                             input logic exp_err, input logic [31:0] exp_dat);
        pending_q.push_back({chk_dat, exp_err, exp_dat});
        pending_adr_q.push_back(adr);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(posedge clk);
        while (!(wb_rsp.ack || wb_rsp.err)) begin
            @(posedge clk);
        end
        wb_req <= '0;
    endtask

    task automatic mem_write(input logic [`ECC_MEM_AW-1:0] addr, input logic [31:0] data);
        ecc_pkg::ecc_word_t word;
        word         = '{chk: calc_parity(data), data: data};
        shadow[addr] = apply_inject(word, inject_m);
        inject_m     = '0;
        bus_cycle(1'b1, mem_adr(addr), data, 1'b0, 1'b0, 32'd0);
    endtask

    task automatic mem_read(input logic [`ECC_MEM_AW-1:0] addr);
        logic               is_err;
        logic [31:0]        rdata;
        logic               single;
        logic               multi;
        ecc_pkg::ecc_word_t new_word;
        predict_read(ctrl_m, shadow[addr], is_err, rdata, single, multi, new_word);
        shadow[addr] = new_word;
        if (single && (sec_m != '1)) begin
            sec_m = sec_m + 32'd1;
        end
        if (multi && (ded_m != '1)) begin
            ded_m = ded_m + 32'd1;
        end
        if (single || multi) begin
            last_m = addr;
        end
        bus_cycle(1'b0, mem_adr(addr), 32'd0, !is_err, is_err, rdata);
    endtask

    task automatic reg_write(input logic [`ECC_REG_SEL_BIT-1:0] off, input logic [31:0] dat);
        case (off)
            `ECC_REG_CTRL:    ctrl_m = ecc_pkg::ecc_ctrl_t'(dat[3:0]);
            `ECC_REG_INJECT:  inject_m = ecc_pkg::ecc_inject_t'(dat[13:0]);
            `ECC_REG_SEC_CNT: sec_m = 32'd0;
            `ECC_REG_DED_CNT: ded_m = 32'd0;
            default:          ;
        endcase
        bus_cycle(1'b1, {1'b1, off}, dat, 1'b0, 1'b0, 32'd0);
    endtask

    task automatic reg_read(input logic [`ECC_REG_SEL_BIT-1:0] off);
        bus_cycle(1'b0, {1'b1, off}, 32'd0, 1'b1, 1'b0, reg_model(off));
    endtask

    task automatic set_ctrl(input logic ce, input logic c1, input logic r1, input logic r2);
        ecc_pkg::ecc_ctrl_t c;
        c = '{check_en: ce, correct_1bit: c1, report_1bit: r1, report_2bit: r2};
        reg_write(`ECC_REG_CTRL, {28'd0, c});
    endtask

    task automatic inject_flips(input logic a_en, input logic [5:0] a_pos,
                                input logic b_en, input logic [5:0] b_pos);
        ecc_pkg::ecc_inject_t inj;
        inj = '{a_en: a_en, a_pos: a_pos, b_en: b_en, b_pos: b_pos};
        reg_write(`ECC_REG_INJECT, {18'd0, inj});
    endtask

    // ****************************************
    // Response compare and watchdog.
    // ****************************************
    always @(posedge clk) begin : compare_rsp
        logic [33:0]           exp_rsp;
        logic [`ECC_ADR_W-1:0] exp_adr;
        if (!reset && (wb_rsp.ack || wb_rsp.err)) begin
            if (pending_q.size() == 0) begin
                $display("Response seen with no transaction outstanding");
                error_count++;
            end else begin
                exp_rsp = pending_q.pop_front();
                exp_adr = pending_adr_q.pop_front();
                check_count++;
                if (wb_rsp.ack && wb_rsp.err) begin
                    $display("Ack and err high together at address %h", exp_adr);
                    error_count++;
                end
                if (wb_rsp.err !== exp_rsp[32]) begin
                    $display("CHECK FAILED wb_rsp.err adr %h: expected %h, got %h",
                             exp_adr, exp_rsp[32], wb_rsp.err);
                    error_count++;
                end else if (exp_rsp[33] && (wb_rsp.dat !== exp_rsp[31:0])) begin
                    $display("CHECK FAILED wb_rsp.dat adr %h: expected %h, got %h",
                             exp_adr, exp_rsp[31:0], wb_rsp.dat);
                    error_count++;
                end
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors %0d in %0d responses", error_count, check_count);
            $display("Checks failed");
            $finish;
        end
    end

    // ****************************************
    // Scenarios.
    // ****************************************
    initial begin : stimulus
        logic [`ECC_MEM_AW-1:0] a;
        logic [5:0]             pa;
        logic [5:0]             pb;
        void'($urandom(32'h4e17_8afb));
        reset     = 1'b1;
        wb_req    = '0;
        ctrl_m    = '0;
        inject_m  = '0;
        sec_m     = '0;
        ded_m     = '0;
        last_m    = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // Reset values.
        reg_read(`ECC_REG_CTRL);
        reg_read(`ECC_REG_INJECT);
        reg_read(`ECC_REG_SEC_CNT);
        reg_read(`ECC_REG_DED_CNT);
        reg_read(`ECC_REG_LAST_ADDR);

        // Clean path.
        set_ctrl(1'b1, 1'b1, 1'b0, 1'b0);
        for (int i = 0; i < N_CLEAN; i++) begin
            clean_addr[i] = 8'($urandom);
            mem_write(clean_addr[i], $urandom);
        end
        for (int i = 0; i < N_CLEAN; i++) begin
            mem_read(clean_addr[i]);
        end
        reg_read(`ECC_REG_SEC_CNT);
        reg_read(`ECC_REG_DED_CNT);

        // Single-bit correction and scrub.
        for (int i = 0; i < N_SEC; i++) begin
            a = 8'($urandom);
            if (i == 0) begin
                pa = 6'($urandom_range(31, 0));
            end else if (i == 1) begin
                pa = 6'($urandom_range(38, 32));
            end else begin
                pa = 6'($urandom_range(38, 0));
            end
            inject_flips(1'b1, pa, 1'b0, 6'd0);
            mem_write(a, $urandom);
            mem_read(a);
            reg_read(`ECC_REG_SEC_CNT);
            reg_read(`ECC_REG_LAST_ADDR);
            mem_read(a);
            reg_read(`ECC_REG_SEC_CNT);
        end

        // Single-bit reporting.
        set_ctrl(1'b1, 1'b1, 1'b1, 1'b0);
        for (int i = 0; i < N_REP; i++) begin
            a = 8'($urandom);
            inject_flips(1'b1, 6'($urandom_range(38, 0)), 1'b0, 6'd0);
            mem_write(a, $urandom);
            mem_read(a);
            reg_read(`ECC_REG_SEC_CNT);
        end

        // Multi-bit errors reported and then invalidated.
        set_ctrl(1'b1, 1'b1, 1'b0, 1'b1);
        for (int i = 0; i < N_DED; i++) begin
            a  = 8'($urandom);
            pa = 6'($urandom_range(38, 0));
            pb = other_pos(pa);
            inject_flips(1'b1, pa, 1'b1, pb);
            mem_write(a, $urandom);
            mem_read(a);
            reg_read(`ECC_REG_DED_CNT);
        end
        set_ctrl(1'b1, 1'b1, 1'b0, 1'b0);
        for (int i = 0; i < N_DED; i++) begin
            a  = 8'($urandom);
            pa = 6'($urandom_range(38, 0));
            pb = other_pos(pa);
            inject_flips(1'b1, pa, 1'b1, pb);
            mem_write(a, $urandom);
            mem_read(a);
            mem_read(a);
            reg_read(`ECC_REG_DED_CNT);
        end

        // With checking off the flip comes back raw.
        set_ctrl(1'b0, 1'b1, 1'b1, 1'b1);
        a = 8'($urandom);
        inject_flips(1'b1, 6'($urandom_range(31, 0)), 1'b0, 6'd0);
        mem_write(a, $urandom);
        mem_read(a);
        reg_read(`ECC_REG_SEC_CNT);
        reg_read(`ECC_REG_DED_CNT);

        // Words that share their low address bits with the registers.
        for (int i = 0; i < N_ALIAS; i++) begin
            mem_write(8'(i), $urandom);
        end

        // Register window.
        reg_write(`ECC_REG_CTRL, $urandom);
        reg_read(`ECC_REG_CTRL);
        reg_write(`ECC_REG_INJECT, $urandom);
        reg_read(`ECC_REG_INJECT);
        reg_write(`ECC_REG_INJECT, 32'd0);
        reg_read(`ECC_REG_INJECT);
        reg_write(`ECC_REG_SEC_CNT, $urandom);
        reg_write(`ECC_REG_DED_CNT, $urandom);
        reg_read(`ECC_REG_SEC_CNT);
        reg_read(`ECC_REG_DED_CNT);
        reg_read(`ECC_REG_LAST_ADDR);
        set_ctrl(1'b1, 1'b1, 1'b0, 1'b0);
        for (int i = 0; i < N_CLEAN; i++) begin
            mem_read(clean_addr[i]);
        end
        for (int i = 0; i < N_ALIAS; i++) begin
            mem_read(8'(i));
        end

        @(posedge clk);
        if (pending_q.size() != 0) begin
            $display("%0d responses never arrived", pending_q.size());
        end
        $display("Errors %0d in %0d responses", error_count, check_count);
        if ((error_count == 0) && (pending_q.size() == 0)) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
